// File: src/amp_cfg_pkg.sv
package amp_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // widths that carry a meaning
  ////////////////////////////////////////////////////////////

  typedef logic [7:0]  reg_byte_t;   // one chip register value or one command byte.
  typedef logic [5:0]  reg_addr_t;   // register address field of a write frame.
  typedef logic [2:0]  cmd_sel_t;    // command slot on the host port.
  typedef logic [15:0] spi_frame_t;  // opcode, address and data of one write.
  typedef logic [3:0]  dev_id_t;     // device identity nibble from mix1.
  typedef logic [3:0]  bw_code_t;    // upper or lower bandwidth code from the filter byte.
  typedef logic [3:0]  adc_opt_t;    // adc sample rate option from mix0.

  ////////////////////////////////////////////////////////////
  // command slots and register addresses
  ////////////////////////////////////////////////////////////

  localparam cmd_sel_t CMD_FILT   = 3'd0;  // upper code in the top nibble, lower below.
  localparam cmd_sel_t CMD_MIX0   = 3'd1;  // adc option and amplifier enable bits.
  localparam cmd_sel_t CMD_MIX1   = 3'd2;  // identity, data input bits and group.
  localparam cmd_sel_t CMD_REG4   = 3'd3;  // raw byte for register 4.
  localparam cmd_sel_t CMD_REG5   = 3'd4;  // raw byte for register 5.
  localparam cmd_sel_t CMD_REG6   = 3'd5;  // raw byte for register 6.
  localparam cmd_sel_t CMD_REG7   = 3'd6;  // raw byte for register 7.
  localparam cmd_sel_t CMD_COMMIT = 3'd7;  // starts the write-out of the whole image.

  localparam logic [1:0] WRITE_OPCODE = 2'b10;  // sits in frame bits 15 and 14.

  localparam int unsigned NUM_FRAMES      = 18;  // registers 0 to 17 per commit.
  localparam int unsigned AMP_POWER_FIRST = 14;  // registers 14 to 17 share one byte.

  localparam adc_opt_t ADC_OPT_MAX = 4'd8;  // the adc tables stop at entry 8.

  ////////////////////////////////////////////////////////////
  // state machines
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    DEC_IDLE,       // waiting for a request.
    DEC_ACK,        // raising the acknowledge.
    DEC_WAIT_DROP   // waiting for the host to drop its request.
  } decode_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,       // no write-out running.
    WR_SEND,       // request freshly raised and address counter advancing.
    WR_WAIT_ACK,   // request held until the consumer acknowledges.
    WR_WAIT_DROP   // request dropped and waiting for the acknowledge to fall.
  } writer_state_t;

endpackage

// File: src/cmd_decode.sv
`timescale 1ns/1ns

module cmd_decode (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_req,   // host request of the four-phase port.
  input  amp_cfg_pkg::cmd_sel_t  cmd_sel,   // slot that cmd_data is meant for.
  input  amp_cfg_pkg::reg_byte_t cmd_data,  // stable while cmd_req is high.
  input  logic                   busy,      // high while the writer sends frames.
  output logic                   cmd_ack,   // slave acknowledge back to the host.
  output logic                   start,     // one-cycle pulse that starts the writer.
  output amp_cfg_pkg::reg_byte_t cmd_filt,
  output amp_cfg_pkg::reg_byte_t cmd_mix0,
  output amp_cfg_pkg::reg_byte_t cmd_mix1,
  output amp_cfg_pkg::reg_byte_t cmd_reg4,
  output amp_cfg_pkg::reg_byte_t cmd_reg5,
  output amp_cfg_pkg::reg_byte_t cmd_reg6,
  output amp_cfg_pkg::reg_byte_t cmd_reg7
);

  amp_cfg_pkg::decode_state_t state;  // slave side of the host handshake.

  ////////////////////////////////////////////////////////////
  // four-phase slave and shadow command bytes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= amp_cfg_pkg::DEC_IDLE;
      cmd_ack  <= 1'b0;
      start    <= 1'b0;
      cmd_filt <= '0;  // the image after reset is built from all-zero bytes.
      cmd_mix0 <= '0;
      cmd_mix1 <= '0;
      cmd_reg4 <= '0;
      cmd_reg5 <= '0;
      cmd_reg6 <= '0;
      cmd_reg7 <= '0;
    end else begin
      start <= 1'b0;  // start is only ever a single cycle wide.
      case (state)
        amp_cfg_pkg::DEC_IDLE: begin
          // a running write-out holds every request off so the shadow bytes stay put.
          if (cmd_req && !busy) begin
            state <= amp_cfg_pkg::DEC_ACK;  // the acknowledge follows one cycle later.
            case (cmd_sel)
              amp_cfg_pkg::CMD_FILT:   cmd_filt <= cmd_data;
              amp_cfg_pkg::CMD_MIX0:   cmd_mix0 <= cmd_data;
              amp_cfg_pkg::CMD_MIX1:   cmd_mix1 <= cmd_data;
              amp_cfg_pkg::CMD_REG4:   cmd_reg4 <= cmd_data;
              amp_cfg_pkg::CMD_REG5:   cmd_reg5 <= cmd_data;
              amp_cfg_pkg::CMD_REG6:   cmd_reg6 <= cmd_data;
              amp_cfg_pkg::CMD_REG7:   cmd_reg7 <= cmd_data;
              amp_cfg_pkg::CMD_COMMIT: start    <= 1'b1;  // data byte is ignored here.
            endcase
          end
        end
        amp_cfg_pkg::DEC_ACK: begin
          cmd_ack <= 1'b1;  // the shadow byte or start is already in place.
          state   <= amp_cfg_pkg::DEC_WAIT_DROP;
        end
        amp_cfg_pkg::DEC_WAIT_DROP: begin
          if (!cmd_req) begin
            cmd_ack <= 1'b0;  // host may request again once it sees this low.
            state   <= amp_cfg_pkg::DEC_IDLE;
          end
        end
        default: begin
          cmd_ack <= 1'b0;  // an unused encoding falls back to idle.
          state   <= amp_cfg_pkg::DEC_IDLE;
        end
      endcase
    end
  end

endmodule

// File: src/reg_image.sv
`timescale 1ns/1ns

module reg_image (
  input  amp_cfg_pkg::reg_byte_t cmd_filt,  // upper code in 7:4 and lower code in 3:0.
  input  amp_cfg_pkg::reg_byte_t cmd_mix0,  // adc option in 7:4 and enables in 3:1.
  input  amp_cfg_pkg::reg_byte_t cmd_mix1,  // identity in 7:4 and data inputs in 3:2.
  input  amp_cfg_pkg::reg_byte_t cmd_reg4,
  input  amp_cfg_pkg::reg_byte_t cmd_reg5,
  input  amp_cfg_pkg::reg_byte_t cmd_reg6,
  input  amp_cfg_pkg::reg_byte_t cmd_reg7,
  output amp_cfg_pkg::reg_byte_t reg00,
  output amp_cfg_pkg::reg_byte_t reg01,
  output amp_cfg_pkg::reg_byte_t reg02,
  output amp_cfg_pkg::reg_byte_t reg03,
  output amp_cfg_pkg::reg_byte_t reg04,
  output amp_cfg_pkg::reg_byte_t reg05,
  output amp_cfg_pkg::reg_byte_t reg06,
  output amp_cfg_pkg::reg_byte_t reg07,
  output amp_cfg_pkg::reg_byte_t reg08,
  output amp_cfg_pkg::reg_byte_t reg09,
  output amp_cfg_pkg::reg_byte_t reg10,
  output amp_cfg_pkg::reg_byte_t reg11,
  output amp_cfg_pkg::reg_byte_t reg12,
  output amp_cfg_pkg::reg_byte_t reg13,
  output amp_cfg_pkg::reg_byte_t regap,     // amplifier power byte for registers 14 to 17.
  output amp_cfg_pkg::dev_id_t   dev_id,
  output logic                   dev_grp
);

  amp_cfg_pkg::bw_code_t upper_code;  // picks the entry of the four upper tables.
  amp_cfg_pkg::bw_code_t lower_code;  // picks the entry of the two lower tables.
  amp_cfg_pkg::adc_opt_t adc_raw;     // option code exactly as the host wrote it.
  amp_cfg_pkg::adc_opt_t adc_code;    // option code clamped to the defined range.

  // entry 0 sits in the lowest byte of each table.
  logic [15:0][7:0] upper_8_tab;  // register 8 per upper bandwidth code.
  logic [15:0][7:0] upper_9_tab;  // register 9 per upper bandwidth code.
  logic [15:0][7:0] upper_a_tab;  // register 10 per upper bandwidth code.
  logic [15:0][7:0] upper_b_tab;  // register 11 per upper bandwidth code.
  logic [15:0][7:0] lower_c_tab;  // register 12 per lower bandwidth code.
  logic [15:0][7:0] lower_d_tab;  // register 13 per lower bandwidth code.
  logic [8:0][7:0]  adc_buf_tab;  // adc buffer bias per sample rate.
  logic [8:0][7:0]  mux_buf_tab;  // mux buffer bias per sample rate.

  ////////////////////////////////////////////////////////////
  // lookup tables
  ////////////////////////////////////////////////////////////

  // upper bandwidth runs from 100 Hz at code 0 to 15 kHz at code 15.
  assign upper_8_tab = 128'h0B11_1621_030D_1B01_2E29_1E06_2A18_2C26;
  assign upper_9_tab = 128'h0000_0000_0101_0102_0203_0509_0A0D_111A;
  assign upper_a_tab = 128'h0810_1725_0D19_2C17_1E24_2B02_0507_0805;
  assign upper_b_tab = 128'h0000_0000_0101_0102_0304_060B_0D10_151F;

  // lower bandwidth runs from 0.25 Hz at code 0 to 500 Hz at code 15.
  assign lower_c_tab = 128'h0D0F_1219_2236_3E05_1228_142A_082C_2338;
  assign lower_d_tab = 128'h0000_0000_0000_0001_0101_0202_0306_1136;

  // sample rate runs from 120 kS/s at option 0 to 700 kS/s at option 8.
  assign adc_buf_tab = 72'h02_0303_0408_0808_1020;
  assign mux_buf_tab = 72'h04_0710_121A_2028_2828;

  ////////////////////////////////////////////////////////////
  // register image
  ////////////////////////////////////////////////////////////

  assign upper_code = cmd_filt[7:4];
  assign lower_code = cmd_filt[3:0];
  assign adc_raw    = cmd_mix0[7:4];
  assign adc_code   = (adc_raw > amp_cfg_pkg::ADC_OPT_MAX) ? amp_cfg_pkg::ADC_OPT_MAX
                                                           : adc_raw;  // 9 to 15 act as 8.

  assign reg00 = 8'hDE;                                  // fixed bias current setting.
  assign reg01 = {2'b00, adc_buf_tab[adc_code][5:0]};    // adc buffer is six bits wide.
  assign reg02 = {2'b00, mux_buf_tab[adc_code][5:0]};    // so is the mux buffer.
  assign reg03 = {6'b00_0000, cmd_mix1[3:2]};            // the two data-input bits.
  assign reg04 = cmd_reg4;                               // raw bytes pass through unchanged.
  assign reg05 = cmd_reg5;
  assign reg06 = cmd_reg6;
  assign reg07 = cmd_reg7;
  assign reg08 = {cmd_mix0[3], upper_8_tab[upper_code][6:0]};  // mix0 bit 3 tops 8 and 9.
  assign reg09 = {cmd_mix0[3], upper_9_tab[upper_code][6:0]};
  assign reg10 = {cmd_mix0[2], upper_a_tab[upper_code][6:0]};  // mix0 bit 2 tops 10 and 11.
  assign reg11 = {cmd_mix0[2], upper_b_tab[upper_code][6:0]};
  assign reg12 = {cmd_mix0[1], lower_c_tab[lower_code][6:0]};  // mix0 bit 1 tops 12 and 13.
  assign reg13 = {cmd_mix0[1], lower_d_tab[lower_code][6:0]};
  assign regap = 8'hFF;                                  // every amplifier stays powered.

  assign dev_id  = cmd_mix1[7:4];  // identity nibble as last written.
  assign dev_grp = cmd_mix1[1];    // group select bit.

endmodule

// File: src/reg_writer.sv
`timescale 1ns/1ns

module reg_writer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,      // one-cycle pulse from the decoder.
  input  amp_cfg_pkg::reg_byte_t  reg00,
  input  amp_cfg_pkg::reg_byte_t  reg01,
  input  amp_cfg_pkg::reg_byte_t  reg02,
  input  amp_cfg_pkg::reg_byte_t  reg03,
  input  amp_cfg_pkg::reg_byte_t  reg04,
  input  amp_cfg_pkg::reg_byte_t  reg05,
  input  amp_cfg_pkg::reg_byte_t  reg06,
  input  amp_cfg_pkg::reg_byte_t  reg07,
  input  amp_cfg_pkg::reg_byte_t  reg08,
  input  amp_cfg_pkg::reg_byte_t  reg09,
  input  amp_cfg_pkg::reg_byte_t  reg10,
  input  amp_cfg_pkg::reg_byte_t  reg11,
  input  amp_cfg_pkg::reg_byte_t  reg12,
  input  amp_cfg_pkg::reg_byte_t  reg13,
  input  amp_cfg_pkg::reg_byte_t  regap,
  input  logic                    frame_ack,  // consumer acknowledge.
  output logic                    busy,       // high for the whole write-out.
  output logic                    frame_req,  // master request of the frame port.
  output amp_cfg_pkg::spi_frame_t frame_data  // stable until the acknowledge falls.
);

  amp_cfg_pkg::writer_state_t state;
  amp_cfg_pkg::reg_addr_t     addr;         // address of the next frame to load.
  amp_cfg_pkg::reg_byte_t     sel_byte;     // image byte for addr.
  amp_cfg_pkg::spi_frame_t    next_frame;   // frame that addr would produce.
  logic                       frames_done;  // every address has been sent.
  logic                       load_frame;   // frame_data takes next_frame this edge.

  ////////////////////////////////////////////////////////////
  // frame assembly
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (addr >= amp_cfg_pkg::reg_addr_t'(amp_cfg_pkg::AMP_POWER_FIRST)) begin
      sel_byte = regap;  // the power byte repeats up to the last address.
    end else begin
      case (addr)
        6'd0:    sel_byte = reg00;
        6'd1:    sel_byte = reg01;
        6'd2:    sel_byte = reg02;
        6'd3:    sel_byte = reg03;
        6'd4:    sel_byte = reg04;
        6'd5:    sel_byte = reg05;
        6'd6:    sel_byte = reg06;
        6'd7:    sel_byte = reg07;
        6'd8:    sel_byte = reg08;
        6'd9:    sel_byte = reg09;
        6'd10:   sel_byte = reg10;
        6'd11:   sel_byte = reg11;
        6'd12:   sel_byte = reg12;
        default: sel_byte = reg13;  // address 13 is the only one left below the power range.
      endcase
    end
  end

  assign next_frame  = {amp_cfg_pkg::WRITE_OPCODE, addr, sel_byte};
  assign frames_done = (addr == amp_cfg_pkg::reg_addr_t'(amp_cfg_pkg::NUM_FRAMES));
  assign load_frame  = ((state == amp_cfg_pkg::WR_IDLE) && start) ||
                       ((state == amp_cfg_pkg::WR_WAIT_DROP) && !frame_ack && !frames_done);

  always_ff @(posedge clk) begin
    if (load_frame) begin
      frame_data <= next_frame;  // held through the whole handshake of this frame.
    end
  end

  ////////////////////////////////////////////////////////////
  // four-phase master
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= amp_cfg_pkg::WR_IDLE;
      addr      <= '0;
      busy      <= 1'b0;
      frame_req <= 1'b0;
    end else begin
      case (state)
        amp_cfg_pkg::WR_IDLE: begin
          if (start) begin
            frame_req <= 1'b1;  // address 0 goes out first.
            busy      <= 1'b1;
            state     <= amp_cfg_pkg::WR_SEND;
          end
        end
        amp_cfg_pkg::WR_SEND: begin
          addr <= addr + 1'b1;  // points at the following register while this one is out.
          if (frame_ack) begin
            frame_req <= 1'b0;
            state     <= amp_cfg_pkg::WR_WAIT_DROP;
          end else begin
            state <= amp_cfg_pkg::WR_WAIT_ACK;
          end
        end
        amp_cfg_pkg::WR_WAIT_ACK: begin
          if (frame_ack) begin
            frame_req <= 1'b0;  // consumer has taken the frame.
            state     <= amp_cfg_pkg::WR_WAIT_DROP;
          end
        end
        amp_cfg_pkg::WR_WAIT_DROP: begin
          if (!frame_ack) begin
            if (frames_done) begin
              busy  <= 1'b0;  // releases the decoder for new commands.
              addr  <= '0;
              state <= amp_cfg_pkg::WR_IDLE;
            end else begin
              frame_req <= 1'b1;  // next frame is loaded on this same edge.
              state     <= amp_cfg_pkg::WR_SEND;
            end
          end
        end
        default: begin
          frame_req <= 1'b0;
          busy      <= 1'b0;
          addr      <= '0;
          state     <= amp_cfg_pkg::WR_IDLE;
        end
      endcase
    end
  end

endmodule

// File: src/amp_cfg_top.sv
`timescale 1ns/1ns

module amp_cfg_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_req,     // host command request.
  input  amp_cfg_pkg::cmd_sel_t   cmd_sel,
  input  amp_cfg_pkg::reg_byte_t  cmd_data,
  input  logic                    frame_ack,   // frame consumer acknowledge.
  output logic                    cmd_ack,
  output logic                    frame_req,
  output amp_cfg_pkg::spi_frame_t frame_data,
  output amp_cfg_pkg::dev_id_t    dev_id,      // follows the last accepted mix1 byte.
  output logic                    dev_grp
);

  logic                   start;  // decoder to writer commit pulse.
  logic                   busy;   // writer to decoder back-pressure.
  amp_cfg_pkg::reg_byte_t cmd_filt, cmd_mix0, cmd_mix1;
  amp_cfg_pkg::reg_byte_t cmd_reg4, cmd_reg5, cmd_reg6, cmd_reg7;
  amp_cfg_pkg::reg_byte_t reg00, reg01, reg02, reg03, reg04, reg05, reg06, reg07;
  amp_cfg_pkg::reg_byte_t reg08, reg09, reg10, reg11, reg12, reg13, regap;

  cmd_decode u_cmd_decode (
    .clk, .rst_n, .cmd_req, .cmd_sel, .cmd_data, .busy,
    .cmd_ack, .start,
    .cmd_filt, .cmd_mix0, .cmd_mix1, .cmd_reg4, .cmd_reg5, .cmd_reg6, .cmd_reg7
  );

  // shadow bytes only move while busy is low so the image needs no storage.
  reg_image u_reg_image (
    .cmd_filt, .cmd_mix0, .cmd_mix1, .cmd_reg4, .cmd_reg5, .cmd_reg6, .cmd_reg7,
    .reg00, .reg01, .reg02, .reg03, .reg04, .reg05, .reg06,
    .reg07, .reg08, .reg09, .reg10, .reg11, .reg12, .reg13,
    .regap, .dev_id, .dev_grp
  );

  reg_writer u_reg_writer (
    .clk, .rst_n, .start,
    .reg00, .reg01, .reg02, .reg03, .reg04, .reg05, .reg06,
    .reg07, .reg08, .reg09, .reg10, .reg11, .reg12, .reg13,
    .regap, .frame_ack,
    .busy, .frame_req, .frame_data
  );

endmodule

// File: testbench/tb_amp_cfg.sv
`timescale 1ns/1ns

module tb_amp_cfg;

  localparam int unsigned FRAMES_PER_COMMIT = 18;     // registers 0 to 17 per write-out.
  localparam int unsigned CYCLE_LIMIT       = 12000;  // 24 configurations of ~400 cycles.

  // entry 0 sits in the lowest byte of each table.
  localparam logic [15:0][7:0] UP8_TAB = 128'h0B11_1621_030D_1B01_2E29_1E06_2A18_2C26;
  localparam logic [15:0][7:0] UP9_TAB = 128'h0000_0000_0101_0102_0203_0509_0A0D_111A;
  localparam logic [15:0][7:0] UPA_TAB = 128'h0810_1725_0D19_2C17_1E24_2B02_0507_0805;
  localparam logic [15:0][7:0] UPB_TAB = 128'h0000_0000_0101_0102_0304_060B_0D10_151F;
  localparam logic [15:0][7:0] LOC_TAB = 128'h0D0F_1219_2236_3E05_1228_142A_082C_2338;
  localparam logic [15:0][7:0] LOD_TAB = 128'h0000_0000_0000_0001_0101_0202_0306_1136;
  localparam logic [8:0][7:0]  ADC_TAB = 72'h02_0303_0408_0808_1020;
  localparam logic [8:0][7:0]  MUX_TAB = 72'h04_0710_121A_2028_2828;

  logic                    clk;
  logic                    rst_n;
  logic                    cmd_req;
  amp_cfg_pkg::cmd_sel_t   cmd_sel;
  amp_cfg_pkg::reg_byte_t  cmd_data;
  logic                    frame_ack;
  logic                    cmd_ack;
  logic                    frame_req;
  amp_cfg_pkg::spi_frame_t frame_data;
  amp_cfg_pkg::dev_id_t    dev_id;
  logic                    dev_grp;

  amp_cfg_pkg::reg_byte_t shadow [0:6];  // host copy of slots 0 to 6.
  int unsigned errors      = 0;
  int unsigned frames_seen = 0;          // frames accepted since reset.
  int unsigned commits     = 0;          // commits issued since reset.
  int unsigned cycles      = 0;
  logic        ack_seen    = 1'b0;       // frame_ack as sampled on the previous edge.

  amp_cfg_top u_amp_cfg_top (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period.
  end

  ////////////////////////////////////////////////////////////
  // reference model and compare tasks
  ////////////////////////////////////////////////////////////

  function automatic amp_cfg_pkg::spi_frame_t expected_frame(input int unsigned addr);
    amp_cfg_pkg::reg_byte_t value;
    logic [3:0] up;
    logic [3:0] lo;
    logic [3:0] adc;
    up  = shadow[0][7:4];
    lo  = shadow[0][3:0];
    adc = (shadow[1][7:4] > 4'd8) ? 4'd8 : shadow[1][7:4];  // only nine rate entries.
    case (addr)
      0:       value = 8'hDE;
      1:       value = {2'b00, ADC_TAB[adc][5:0]};
      2:       value = {2'b00, MUX_TAB[adc][5:0]};
      3:       value = {6'd0, shadow[2][3:2]};
      4, 5, 6, 7: value = shadow[addr - 1];  // raw slots 3 to 6.
      8:       value = {shadow[1][3], UP8_TAB[up][6:0]};
      9:       value = {shadow[1][3], UP9_TAB[up][6:0]};
      10:      value = {shadow[1][2], UPA_TAB[up][6:0]};
      11:      value = {shadow[1][2], UPB_TAB[up][6:0]};
      12:      value = {shadow[1][1], LOC_TAB[lo][6:0]};
      13:      value = {shadow[1][1], LOD_TAB[lo][6:0]};
      default: value = 8'hFF;  // amplifier power byte.
    endcase
    return {2'b10, 6'(addr), value};
  endfunction

  task automatic check_frame(input amp_cfg_pkg::spi_frame_t got,
                             input amp_cfg_pkg::spi_frame_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_dev_id(input amp_cfg_pkg::dev_id_t got,
                              input amp_cfg_pkg::dev_id_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // every frame is checked on the edge where its acknowledge is first sampled high.
  always @(posedge clk) begin
    if (frame_ack && !ack_seen) begin
      if (frames_seen >= commits * FRAMES_PER_COMMIT) begin
        errors++;
        $display("an extra frame %h was sent with no commit pending", frame_data);
      end else begin
        check_frame(frame_data, expected_frame(frames_seen % FRAMES_PER_COMMIT), "frame");
      end
      frames_seen++;
    end
    ack_seen = frame_ack;
  end

  ////////////////////////////////////////////////////////////
  // host, consumer and timeout
  ////////////////////////////////////////////////////////////

  task automatic send_cmd(input amp_cfg_pkg::cmd_sel_t sel, input amp_cfg_pkg::reg_byte_t data);
    @(posedge clk);
    cmd_sel  <= sel;
    cmd_data <= data;
    cmd_req  <= 1'b1;
    do @(posedge clk); while (!cmd_ack);  // held here for as long as a write-out runs.
    if (sel != 3'd7) shadow[sel] = data;
    if (sel == 3'd2) begin
      check_dev_id(dev_id, data[7:4], "dev_id after mix1");
      check_bit(dev_grp, data[1], "dev_grp after mix1");
    end
    cmd_req <= 1'b0;
    do @(posedge clk); while (cmd_ack);
  endtask

  task automatic run_commit();
    commits++;  // counted first so the frames that follow are expected.
    send_cmd(3'd7, 8'h00);
  endtask

  task automatic wait_write_out();
    int unsigned n;
    n = 0;
    while (frames_seen < commits * FRAMES_PER_COMMIT && n < 600) begin
      @(posedge clk);
      n++;
    end
    if (frames_seen != commits * FRAMES_PER_COMMIT) begin
      errors++;
      $display("write-out stopped after %0d of %0d frames", frames_seen,
               commits * FRAMES_PER_COMMIT);
    end
  endtask

  initial begin
    int unsigned delay;
    frame_ack = 1'b0;
    forever begin
      @(posedge clk);
      if (frame_req && !frame_ack) begin
        delay = $urandom_range(5, 0);  // consumer answers after 0 to 5 cycles.
        repeat (delay) @(posedge clk);
        frame_ack <= 1'b1;
        do @(posedge clk); while (frame_req);
        frame_ack <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped at the cycle limit, %0d errors", errors);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'he933));
    rst_n    = 1'b0;
    cmd_req  = 1'b0;
    cmd_sel  = '0;
    cmd_data = '0;
    for (int s = 0; s < 7; s++) shadow[s] = 8'h00;  // shadow bytes clear on reset.
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    repeat (5) @(posedge clk);
    check_bit(cmd_ack, 1'b0, "cmd_ack after reset");
    check_bit(frame_req, 1'b0, "frame_req after reset");
    send_cmd(3'd0, 8'h5A);  // commands alone must not start a write-out.
    send_cmd(3'd3, 8'hC3);
    for (int i = 0; i < 24; i++) begin
      send_cmd(3'd0, 8'($urandom));
      send_cmd(3'd1, {4'(i), 4'($urandom)});  // adc codes 0 to 15 where 9 and up clamp to 8.
      send_cmd(3'd2, 8'($urandom));
      for (int r = 3; r < 7; r++) send_cmd(3'(r), 8'($urandom));
      run_commit();
      if (i == 23) begin
        run_commit();  // a second commit waits for the first write-out.
        if (frames_seen != (commits - 1) * FRAMES_PER_COMMIT) begin
          errors++;
          $display("second commit was taken while a write-out was running");
        end
      end else if (i % 4 == 3) begin
        send_cmd(3'd0, 8'($urandom));  // held off until the write-out ends.
        if (frames_seen != commits * FRAMES_PER_COMMIT) begin
          errors++;
          $display("a command was taken while a write-out was running");
        end
        run_commit();  // the new filter byte must show in these frames.
      end
      wait_write_out();
    end
    repeat (20) @(posedge clk);  // no frame may follow the last write-out.
    $display("run finished, %0d frames, %0d errors", frames_seen, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: amp_cfg.f
src/amp_cfg_pkg.sv
src/cmd_decode.sv
src/reg_image.sv
src/reg_writer.sv
src/amp_cfg_top.sv
testbench/tb_amp_cfg.sv

// File: Bender.yml
package:
  name: amp_cfg

sources:
  - files:
      - src/amp_cfg_pkg.sv
      - src/cmd_decode.sv
      - src/reg_image.sv
      - src/reg_writer.sv
      - src/amp_cfg_top.sv
  - target: simulation
    files:
      - testbench/tb_amp_cfg.sv
